// ==== Makefile ====
# Verilator simulation of the transport stream capture subsystem

VERILATOR ?= verilator
TOP       ?= tsp_dump_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
SIMARGS   ?= +verilator+error+limit+1000
FAIL_MSG  ?= STATUS: FAIL
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/ts_axis_master.sv ====
`default_nettype none

module ts_axis_master #(
	parameter int FIFO_DEPTH_WORDS = 256
) (
	input  wire logic                              ts_clk,
	input  wire logic                              S_AXI_ARESETN,
	input  wire logic [$clog2(FIFO_DEPTH_WORDS):0] commit_count,
	input  wire tsp_pkg::ts_word_t                 rd_data,
	input  wire logic                              rd_last,
	output logic                                   rd_en,
	output logic                                   axis_tvalid,
	output tsp_pkg::ts_word_t                      axis_tdata,
	output logic                                   axis_tlast,
	input  wire logic                              axis_tready
);

	logic words_left;
	logic reg_free;

	// The register can take a word when empty or when its word leaves this cycle
	assign words_left = (commit_count != '0);
	assign reg_free   = !axis_tvalid || axis_tready;
	assign rd_en      = words_left && reg_free;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			axis_tvalid <= 1'b0;
		end else if (rd_en) begin
			axis_tvalid <= 1'b1;
		end else if (axis_tready) begin
			axis_tvalid <= 1'b0;
		end
	end

	// Data only changes on a refill, so it holds while tready is low
	always_ff @(posedge ts_clk) begin
		if (rd_en) begin
			axis_tdata <= rd_data;
			axis_tlast <= rd_last;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ts_packet_capture.sv ====
`default_nettype none

module ts_packet_capture (
	input  wire logic               ts_clk,
	input  wire logic               S_AXI_ARESETN,
	input  wire logic               ts_valid,
	input  wire logic               ts_sync,
	input  wire tsp_pkg::ts_byte_t  ts_data,
	input  wire logic               filter_en,
	input  wire tsp_pkg::ts_pid_t   pid_a,
	input  wire tsp_pkg::ts_pid_t   pid_b,
	output logic                    cap_valid,
	output tsp_pkg::cap_byte_s      cap_byte
);
	import tsp_pkg::*;

	localparam byte_count_t last_index = byte_count_t'(ts_packet_bytes - 1);

	capture_state_e state;
	byte_count_t    count;
	logic [4:0]     pid_hi;
	ts_pid_t        pid;
	logic           keep;
	logic           in_packet;
	logic           sync_ok;
	logic           hdr_byte;
	logic           end_byte;

	assign in_packet = (state == header) || (state == payload);
	assign sync_ok   = (ts_data == ts_sync_byte);
	assign hdr_byte  = ts_valid && !ts_sync && (state == header);
	assign end_byte  = !ts_sync && (state == payload) && (count == last_index);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Framing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// count holds the index of the next expected byte
	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			state     <= hunt;
			count     <= '0;
			cap_valid <= 1'b0;
		end else begin
			cap_valid <= 1'b0;
			if (ts_valid && ts_sync) begin
				// An early sync still has to reach the packer so it can drop the packet
				cap_valid <= sync_ok || in_packet;
				count     <= byte_count_t'(1);
				state     <= sync_ok ? header : discard;
			end else if (ts_valid && in_packet) begin
				cap_valid <= 1'b1;
				count     <= count + byte_count_t'(1);
				if ((state == header) && (count == byte_count_t'(3))) begin
					state <= payload;
				end
				if (end_byte) begin
					state <= hunt;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PID and filter verdict
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// The PID is complete after byte 2, so the verdict is ready at byte 3
	always_ff @(posedge ts_clk) begin
		if (hdr_byte) begin
			case (count)
				byte_count_t'(1): pid_hi <= ts_data[4:0];
				byte_count_t'(2): pid <= {pid_hi, ts_data};
				byte_count_t'(3): keep <= !filter_en || (pid == pid_a) || (pid == pid_b);
				default: ;
			endcase
		end
	end

	always_ff @(posedge ts_clk) begin
		if (ts_valid) begin
			cap_byte.data  <= ts_data;
			cap_byte.first <= ts_sync && sync_ok;
			cap_byte.last  <= end_byte;
			cap_byte.keep  <= keep;
			cap_byte.abort <= ts_sync && in_packet;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ts_packet_fifo.sv ====
`default_nettype none

module ts_packet_fifo #(
	parameter int FIFO_DEPTH_WORDS = 256
) (
	input  wire logic                              ts_clk,
	input  wire logic                              S_AXI_ARESETN,
	input  wire logic                              word_valid,
	input  wire tsp_pkg::ts_word_s                 word,
	input  wire logic                              rd_en,
	output tsp_pkg::ts_word_t                      rd_data,
	output logic                                   rd_last,
	output logic [$clog2(FIFO_DEPTH_WORDS):0]      commit_count,
	output logic                                   packet_ready,
	output logic                                   error_full
);
	import tsp_pkg::*;

	localparam int addr_w  = $clog2(FIFO_DEPTH_WORDS);
	localparam int entry_w = $bits(ts_word_t) + 1;

	typedef logic [addr_w:0] ptr_t;

	logic [entry_w-1:0] mem [FIFO_DEPTH_WORDS];

	ptr_t wr_ptr;
	ptr_t wr_next;
	ptr_t start_ptr;
	ptr_t commit_ptr;
	ptr_t rd_ptr;
	ptr_t used;
	logic full;
	logic overflow;
	logic accept;

	// Pointers carry one extra bit so a full buffer differs from an empty one
	assign used         = wr_ptr - rd_ptr;
	assign full         = used[addr_w];
	assign wr_next      = wr_ptr + 1'b1;
	assign accept       = word_valid && !word.abort && !overflow && !full;
	assign commit_count = commit_ptr - rd_ptr;
	assign packet_ready = (commit_count != '0);

	assign {rd_last, rd_data} = mem[rd_ptr[addr_w-1:0]];

	always_ff @(posedge ts_clk) begin
		if (accept) begin
			mem[wr_ptr[addr_w-1:0]] <= {word.last, word.data};
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Packet commit and rewind
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			wr_ptr     <= '0;
			start_ptr  <= '0;
			commit_ptr <= '0;
			rd_ptr     <= '0;
			overflow   <= 1'b0;
			error_full <= 1'b0;
		end else begin
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (word_valid) begin
				if (word.abort) begin
					wr_ptr   <= start_ptr;
					overflow <= 1'b0;
				end else if (!accept) begin
					// Once a word is lost the rest of the packet is dropped too
					error_full <= 1'b1;
					overflow   <= !word.last;
					if (word.last) begin
						wr_ptr <= start_ptr;
					end
				end else if (word.last && word.keep) begin
					wr_ptr     <= wr_next;
					start_ptr  <= wr_next;
					commit_ptr <= wr_next;
				end else if (word.last) begin
					wr_ptr <= start_ptr;
				end else begin
					wr_ptr <= wr_next;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ts_word_packer.sv ====
`default_nettype none

module ts_word_packer (
	input  wire logic                ts_clk,
	input  wire logic                S_AXI_ARESETN,
	input  wire logic                cap_valid,
	input  wire tsp_pkg::cap_byte_s  cap_byte,
	output logic                     word_valid,
	output tsp_pkg::ts_word_s        word
);
	import tsp_pkg::*;

	localparam int byte_w = $bits(ts_byte_t);
	localparam int acc_w  = $bits(ts_word_t) - byte_w;

	logic [1:0]       lane;
	logic [acc_w-1:0] acc;
	logic             word_done;
	logic             abort_in;

	assign abort_in  = cap_valid && cap_byte.abort;
	assign word_done = cap_valid && !cap_byte.abort && (lane == 2'd3);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lane tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A first byte always lands in lane 0, even when it arrives with an abort
	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			lane       <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= word_done || abort_in;
			if (cap_valid) begin
				if (cap_byte.first) begin
					lane <= 2'd1;
				end else if (cap_byte.abort) begin
					lane <= 2'd0;
				end else begin
					lane <= lane + 2'd1;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte assembly
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Earlier bytes shift up so byte 0 of each word ends in the top lane
	always_ff @(posedge ts_clk) begin
		if (cap_valid) begin
			acc <= {acc[acc_w-byte_w-1:0], cap_byte.data};
		end
	end

	// On an abort only the abort flag matters to the FIFO
	always_ff @(posedge ts_clk) begin
		if (cap_valid) begin
			word.data  <= {acc, cap_byte.data};
			word.last  <= cap_byte.last;
			word.keep  <= cap_byte.keep;
			word.abort <= cap_byte.abort;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tsp_dump.sv ====
`default_nettype none

module tsp_dump #(
	parameter int FIFO_DEPTH_WORDS = 256
) (
	input  wire logic               ts_clk,
	input  wire logic               S_AXI_ARESETN,
	input  wire logic               ts_valid,
	input  wire logic               ts_sync,
	input  wire tsp_pkg::ts_byte_t  ts_data,
	input  wire logic               filter_en,
	input  wire tsp_pkg::ts_pid_t   pid_a,
	input  wire tsp_pkg::ts_pid_t   pid_b,
	output wire logic               axis_tvalid,
	output wire tsp_pkg::ts_word_t  axis_tdata,
	output wire logic               axis_tlast,
	input  wire logic               axis_tready,
	output wire logic               packet_ready,
	output wire logic               error_full
);
	import tsp_pkg::*;

	wire logic                              cap_valid;
	wire cap_byte_s                         cap_byte;
	wire logic                              word_valid;
	wire ts_word_s                          word;
	wire logic                              rd_en;
	wire ts_word_t                          rd_data;
	wire logic                              rd_last;
	wire logic [$clog2(FIFO_DEPTH_WORDS):0] commit_count;

	ts_packet_capture capture (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ts_valid      (ts_valid),
		.ts_sync       (ts_sync),
		.ts_data       (ts_data),
		.filter_en     (filter_en),
		.pid_a         (pid_a),
		.pid_b         (pid_b),
		.cap_valid     (cap_valid),
		.cap_byte      (cap_byte)
	);

	ts_word_packer packer (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.cap_valid     (cap_valid),
		.cap_byte      (cap_byte),
		.word_valid    (word_valid),
		.word          (word)
	);

	ts_packet_fifo #(
		.FIFO_DEPTH_WORDS (FIFO_DEPTH_WORDS)
	) fifo (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.word_valid    (word_valid),
		.word          (word),
		.rd_en         (rd_en),
		.rd_data       (rd_data),
		.rd_last       (rd_last),
		.commit_count  (commit_count),
		.packet_ready  (packet_ready),
		.error_full    (error_full)
	);

	ts_axis_master #(
		.FIFO_DEPTH_WORDS (FIFO_DEPTH_WORDS)
	) master (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.commit_count  (commit_count),
		.rd_data       (rd_data),
		.rd_last       (rd_last),
		.rd_en         (rd_en),
		.axis_tvalid   (axis_tvalid),
		.axis_tdata    (axis_tdata),
		.axis_tlast    (axis_tlast),
		.axis_tready   (axis_tready)
	);

endmodule

`default_nettype wire

// ==== hdl/tsp_pkg.sv ====
`default_nettype none

package tsp_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths that carry a meaning
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [7:0]  ts_byte_t;
	typedef logic [12:0] ts_pid_t;
	typedef logic [31:0] ts_word_t;
	typedef logic [7:0]  byte_count_t;

	localparam int unsigned ts_packet_bytes     = 188;
	localparam ts_byte_t    ts_sync_byte        = 8'h47;
	localparam int unsigned ts_words_per_packet = 47;

	// One accepted byte on its way to the packer
	typedef struct packed {
		ts_byte_t data;
		logic     first;
		logic     last;
		logic     keep;
		logic     abort;
	} cap_byte_s;

	// One packed word on its way to the FIFO
	typedef struct packed {
		ts_word_t data;
		logic     last;
		logic     keep;
		logic     abort;
	} ts_word_s;

	typedef enum logic [1:0] {
		hunt,
		header,
		payload,
		discard
	} capture_state_e;

endpackage

`default_nettype wire

// ==== sim.f ====
hdl/tsp_pkg.sv
hdl/ts_packet_capture.sv
hdl/ts_word_packer.sv
hdl/ts_packet_fifo.sv
hdl/ts_axis_master.sv
hdl/tsp_dump.sv
verification/tsp_dump_asserts.sv
verification/tsp_dump_tb.sv

// ==== verification/tsp_dump_asserts.sv ====
`default_nettype none

module tsp_dump_asserts (
	input wire logic              ts_clk,
	input wire logic              S_AXI_ARESETN,
	input wire logic              axis_tvalid,
	input wire logic              axis_tready,
	input wire tsp_pkg::ts_word_t axis_tdata,
	input wire logic              axis_tlast,
	input wire logic              error_full
);
	timeunit 1ns;
	timeprecision 100ps;
	import tsp_pkg::*;

	localparam logic [5:0] last_beat = 6'(ts_words_per_packet - 1);

	int unsigned failures = 0;
	logic [5:0]  beat_count;

	// Position of the next transfer within its packet
	always_ff @(posedge ts_clk) begin
		if (!S_AXI_ARESETN) begin
			beat_count <= '0;
		end else if (axis_tvalid && axis_tready) begin
			beat_count <= (beat_count == last_beat) ? '0 : beat_count + 6'd1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output protocol
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	tvalid_low_in_reset: assert property (@(posedge ts_clk)
		!S_AXI_ARESETN |=> !axis_tvalid)
	else begin
		$error("axis_tvalid high after a reset cycle");
		failures++;
	end

	// A stalled word keeps its data and its valid until it moves
	held_under_backpressure: assert property (@(posedge ts_clk) disable iff (!S_AXI_ARESETN)
		(axis_tvalid && !axis_tready) |=>
			(axis_tvalid && $stable(axis_tdata) && $stable(axis_tlast)))
	else begin
		$error("Output word changed or was withdrawn while axis_tready was low");
		failures++;
	end

	tlast_every_packet: assert property (@(posedge ts_clk) disable iff (!S_AXI_ARESETN)
		(axis_tvalid && axis_tready) |-> (axis_tlast == (beat_count == last_beat)))
	else begin
		$error("axis_tlast not on the last word of a packet");
		failures++;
	end

	error_full_sticky: assert property (@(posedge ts_clk) disable iff (!S_AXI_ARESETN)
		error_full |=> error_full)
	else begin
		$error("error_full fell outside reset");
		failures++;
	end

endmodule

bind tsp_dump tsp_dump_asserts protocol_checks (.*);

`default_nettype wire

// ==== verification/tsp_dump_tb.sv ====
`default_nettype none

module tsp_dump_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import tsp_pkg::*;

	localparam int          clk_period    = 20;
	localparam int          drive_delay   = 2;
	localparam int          fifo_depth    = 256;
	localparam int          pkt_len       = ts_packet_bytes;
	localparam int          words_per_pkt = ts_words_per_packet;
	localparam int          short_length  = 100;
	localparam int          total_packets = 28;
	localparam int          drain_limit   = 2000;
	// One valid byte in four, at most one random idle per byte, then drains and reset
	localparam int          cycle_limit   = total_packets * pkt_len * 4
		+ total_packets * pkt_len + 4000;
	localparam logic [31:0] seed          = 32'h69c5_20eb;

	localparam int kind_good     = 0;
	localparam int kind_bad_sync = 1;
	localparam int kind_short    = 2;

	logic     ts_clk;
	logic     S_AXI_ARESETN;
	logic     ts_valid;
	logic     ts_sync;
	ts_byte_t ts_data;
	logic     filter_en;
	ts_pid_t  pid_a;
	ts_pid_t  pid_b;
	logic     axis_tready;
	logic     axis_tvalid;
	ts_word_t axis_tdata;
	logic     axis_tlast;
	logic     packet_ready;
	logic     error_full;

	logic [31:0] rng_state;
	logic        ready_random;
	logic [32:0] exp_q [$];
	logic [32:0] expected;
	ts_byte_t    pkt_bytes [pkt_len];
	int          error_count  = 0;
	int          cycle_count  = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;

	tsp_dump #(
		.FIFO_DEPTH_WORDS (fifo_depth)
	) uut (
		.ts_clk        (ts_clk),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.ts_valid      (ts_valid),
		.ts_sync       (ts_sync),
		.ts_data       (ts_data),
		.filter_en     (filter_en),
		.pid_a         (pid_a),
		.pid_b         (pid_b),
		.axis_tvalid   (axis_tvalid),
		.axis_tdata    (axis_tdata),
		.axis_tlast    (axis_tlast),
		.axis_tready   (axis_tready),
		.packet_ready  (packet_ready),
		.error_full    (error_full)
	);

	always #(clk_period / 2) ts_clk = !ts_clk;

	always @(posedge ts_clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Helpers and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic int errors_so_far();
		return error_count + int'(uut.protocol_checks.failures);
	endfunction

	function automatic logic packet_kept(input ts_pid_t pid);
		return !filter_en || (pid == pid_a) || (pid == pid_b);
	endfunction

	task automatic next_cycle();
		logic [31:0] r;
		@(posedge ts_clk);
		#drive_delay;
		if (ready_random) begin
			r = xorshift();
			axis_tready = r[4];
		end
	endtask

	task automatic set_ready(input logic random, input logic level);
		ready_random = random;
		axis_tready  = level;
	endtask

	task automatic send_byte(input ts_byte_t value, input logic sync);
		logic [31:0] r;
		ts_valid = 1'b1;
		ts_sync  = sync;
		ts_data  = value;
		next_cycle();
		ts_valid = 1'b0;
		ts_sync  = 1'b0;
		repeat (3) next_cycle();
		r = xorshift();
		if (r[2:0] == 3'd0) begin
			next_cycle();
		end
	endtask

	// A packet is lost when its words do not fit behind those still waiting
	task automatic queue_expected(input ts_pid_t pid);
		int w;
		if (packet_kept(pid) && (exp_q.size() + words_per_pkt <= fifo_depth)) begin
			for (w = 0; w < words_per_pkt; w++) begin
				exp_q.push_back({w == words_per_pkt - 1,
					pkt_bytes[4 * w], pkt_bytes[4 * w + 1],
					pkt_bytes[4 * w + 2], pkt_bytes[4 * w + 3]});
			end
		end
	endtask

	task automatic send_packet(input ts_pid_t pid, input int kind);
		logic [31:0] r;
		int          length;
		int          i;
		r = xorshift();
		pkt_bytes[0] = (kind == kind_bad_sync) ? 8'hb8 : ts_sync_byte;
		pkt_bytes[1] = {r[7:5], pid[12:8]};
		pkt_bytes[2] = pid[7:0];
		pkt_bytes[3] = r[15:8];
		for (i = 4; i < pkt_len; i++) begin
			r = xorshift();
			pkt_bytes[i] = r[7:0];
		end
		length = (kind == kind_short) ? short_length : pkt_len;
		if (kind == kind_good) begin
			queue_expected(pid);
		end
		for (i = 0; i < length; i++) begin
			send_byte(pkt_bytes[i], i == 0);
		end
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < drain_limit) begin
			next_cycle();
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			$display("Output stalled at %0t with %0d words still expected", $time, exp_q.size());
			error_count++;
		end
		// Quiet window so that stray words from dropped packets show up
		repeat (60) next_cycle();
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (errors_so_far() == errors_before) begin
			$display("Test %0d (%s) passed", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d (%s) failed with %0d errors", tests_run, name,
				errors_so_far() - errors_before);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scoreboard
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge ts_clk) begin
		if (S_AXI_ARESETN && axis_tvalid && axis_tready) begin
			assert (exp_q.size() != 0) else begin
				$display("Unexpected transfer at %0t of word %h", $time, axis_tdata);
				error_count++;
			end
			if (exp_q.size() != 0) begin
				expected = exp_q.pop_front();
				assert (axis_tdata == expected[31:0]) else begin
					$display("Mismatch at %0t: axis_tdata got %h expected %h",
						$time, axis_tdata, expected[31:0]);
					error_count++;
				end
				assert (axis_tlast == expected[32]) else begin
					$display("Mismatch at %0t: axis_tlast got %b expected %b",
						$time, axis_tlast, expected[32]);
					error_count++;
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		int mark;
		int waited;
		int i;
		ts_clk        = 1'b0;
		S_AXI_ARESETN = 1'b0;
		ts_valid      = 1'b0;
		ts_sync       = 1'b0;
		ts_data       = '0;
		filter_en     = 1'b0;
		pid_a         = '0;
		pid_b         = '0;
		axis_tready   = 1'b0;
		ready_random  = 1'b0;
		rng_state     = seed;
		repeat (4) next_cycle();
		S_AXI_ARESETN = 1'b1;
		next_cycle();
		assert (!axis_tvalid && !packet_ready && !error_full) else begin
			$display("Outputs were not idle after reset at %0t", $time);
			error_count++;
		end

		mark = errors_so_far();
		set_ready(1'b0, 1'b1);
		for (i = 0; i < 4; i++) begin
			send_packet(ts_pid_t'(xorshift()), kind_good);
		end
		wait_drained();
		end_test("filter off", mark);

		mark = errors_so_far();
		filter_en = 1'b1;
		pid_a     = 13'h0100;
		pid_b     = 13'h1abc;
		send_packet(13'h0100, kind_good);
		send_packet(13'h0200, kind_good);
		send_packet(13'h1abc, kind_good);
		send_packet(13'h1fff, kind_good);
		send_packet(13'h0100, kind_good);
		send_packet(13'h0101, kind_good);
		wait_drained();
		end_test("pid filter", mark);

		mark = errors_so_far();
		filter_en = 1'b0;
		send_packet(13'h0011, kind_good);
		send_packet(13'h0012, kind_bad_sync);
		send_packet(13'h0013, kind_good);
		send_packet(13'h0014, kind_short);
		send_packet(13'h0015, kind_good);
		send_packet(13'h0016, kind_good);
		wait_drained();
		end_test("malformed input", mark);

		mark = errors_so_far();
		filter_en = 1'b1;
		set_ready(1'b1, 1'b0);
		send_packet(13'h0100, kind_good);
		send_packet(13'h0033, kind_good);
		send_packet(13'h1abc, kind_good);
		send_packet(13'h0100, kind_good);
		send_packet(13'h1abc, kind_good);
		set_ready(1'b0, 1'b0);
		send_packet(13'h1abc, kind_good);
		waited = 0;
		while (!packet_ready && waited < 10) begin
			next_cycle();
			waited++;
		end
		assert (packet_ready) else begin
			$display("packet_ready stayed low at %0t with a committed packet waiting", $time);
			error_count++;
		end
		set_ready(1'b1, 1'b0);
		wait_drained();
		assert (!packet_ready) else begin
			$display("packet_ready stayed high at %0t after the output drained", $time);
			error_count++;
		end
		end_test("back-pressure", mark);

		// Five packets fill 235 of the 256 words and the sixth cannot fit
		mark = errors_so_far();
		assert (!error_full) else begin
			$display("error_full was already high at %0t before any overflow", $time);
			error_count++;
		end
		filter_en = 1'b0;
		set_ready(1'b0, 1'b0);
		for (i = 0; i < 6; i++) begin
			send_packet(ts_pid_t'(xorshift()), kind_good);
		end
		waited = 0;
		while (!error_full && waited < 10) begin
			next_cycle();
			waited++;
		end
		assert (error_full) else begin
			$display("error_full did not rise at %0t after the FIFO overflowed", $time);
			error_count++;
		end
		set_ready(1'b0, 1'b1);
		wait_drained();
		end_test("overflow", mark);

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			errors_so_far());
		if (tests_failed == 0 && errors_so_far() == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
